// ==== eth_loop_pkg.sv ====
// Shared types for the two-port Ethernet loopback core

package eth_loop_pkg;

    // Stream data word and its byte-valid mask
    typedef logic [63:0] word_t;
    typedef logic [7:0]  keep_t;

    // APB byte address and data word
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Frame counter, wraps at the top
    typedef logic [15:0] count_t;

    // Write side of the frame FIFO
    typedef enum logic [1:0] {
        wr_idle,
        wr_store,
        wr_drop
    } wr_state_t;

endpackage

// ==== frame_fifo.sv ====
// Store-and-forward frame FIFO that drops bad, oversize, overflowing and disabled frames
`timescale 1ns/1ps

module frame_fifo #(
    parameter int DEPTH     = 64,
    parameter int MAX_WORDS = 16
) (
    input  logic                clk_125mhz,
    input  logic                reset,
    input  logic                port_enable,

    // Receive stream
    input  logic                rx_valid,
    input  eth_loop_pkg::word_t rx_data,
    input  eth_loop_pkg::keep_t rx_keep,
    input  logic                rx_last,
    input  logic                rx_user,

    // Transmit stream
    output logic                tx_valid,
    output eth_loop_pkg::word_t tx_data,
    output eth_loop_pkg::keep_t tx_keep,
    output logic                tx_last,
    input  logic                tx_ready,

    // Frame status pulses
    output logic                good_frame,
    output logic                drop_frame
);

    import eth_loop_pkg::*;

    localparam int AW    = $clog2(DEPTH);
    localparam int PTR_W = AW + 1;
    localparam int CW    = $clog2(MAX_WORDS + 1);

    // Frame storage
    word_t            mem_data [DEPTH];
    keep_t            mem_keep [DEPTH];
    logic             mem_last [DEPTH];

    // Extra pointer bit tells full from empty
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] commit_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] used;

    logic [CW-1:0]    wr_cnt;
    wr_state_t        wr_state;
    logic             drop_silent;

    logic             fifo_full;
    logic             oversize;
    logic             start_off;
    logic             store_word;
    logic             rd_load;

    always_comb begin
        used       = wr_ptr - rd_ptr;
        fifo_full  = (used == PTR_W'(DEPTH));
        // Frame already holds the largest allowed length
        oversize   = (wr_state == wr_store) && (wr_cnt == CW'(MAX_WORDS));
        start_off  = (wr_state == wr_idle) && !port_enable;
        store_word = rx_valid && (wr_state != wr_drop) && !start_off
                     && !fifo_full && !oversize;
        rd_load    = (rd_ptr != commit_ptr) && (!tx_valid || tx_ready);
    end

    // Write side state machine
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            wr_state    <= wr_idle;
            wr_ptr      <= '0;
            commit_ptr  <= '0;
            wr_cnt      <= '0;
            drop_silent <= 1'b0;
            good_frame  <= 1'b0;
            drop_frame  <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            drop_frame <= 1'b0;
            if (rx_valid) begin
                if (wr_state == wr_drop) begin
                    // Throw away whatever part of the frame was stored
                    if (rx_last) begin
                        wr_ptr     <= commit_ptr;
                        drop_frame <= !drop_silent;
                        wr_state   <= wr_idle;
                    end
                end else if (start_off) begin
                    // Port off at first word, frame is ignored and not counted
                    drop_silent <= 1'b1;
                    if (!rx_last) begin
                        wr_state <= wr_drop;
                    end
                end else if (!store_word) begin
                    // Out of room or too long
                    drop_silent <= 1'b0;
                    if (rx_last) begin
                        wr_ptr     <= commit_ptr;
                        drop_frame <= 1'b1;
                        wr_state   <= wr_idle;
                    end else begin
                        wr_state <= wr_drop;
                    end
                end else if (rx_last) begin
                    wr_state <= wr_idle;
                    if (rx_user) begin
                        wr_ptr     <= commit_ptr;
                        drop_frame <= 1'b1;
                    end else begin
                        wr_ptr     <= wr_ptr + 1'b1;
                        commit_ptr <= wr_ptr + 1'b1;
                        good_frame <= 1'b1;
                    end
                end else begin
                    wr_ptr   <= wr_ptr + 1'b1;
                    wr_cnt   <= (wr_state == wr_idle) ? CW'(1) : wr_cnt + 1'b1;
                    wr_state <= wr_store;
                end
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (store_word) begin
            mem_data[wr_ptr[AW-1:0]] <= rx_data;
            mem_keep[wr_ptr[AW-1:0]] <= rx_keep;
            mem_last[wr_ptr[AW-1:0]] <= rx_last;
        end
    end

    // Read side only sees committed words
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            tx_valid <= 1'b0;
            rd_ptr   <= '0;
        end else if (rd_load) begin
            tx_valid <= 1'b1;
            rd_ptr   <= rd_ptr + 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rd_load) begin
            tx_data <= mem_data[rd_ptr[AW-1:0]];
            tx_keep <= mem_keep[rd_ptr[AW-1:0]];
            tx_last <= mem_last[rd_ptr[AW-1:0]];
        end
    end

endmodule

// ==== loop_regs.sv ====
// APB register block with port enables, per-port frame counters and activity LEDs
`timescale 1ns/1ps

module loop_regs #(
    parameter int CNT      = 2,
    parameter int LED_HOLD = 1024
) (
    input  logic                    clk_125mhz,
    input  logic                    reset,

    // APB slave, zero wait states
    input  eth_loop_pkg::apb_addr_t paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  eth_loop_pkg::apb_data_t pwdata,
    output eth_loop_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr,

    // Per-port status and control
    input  logic [CNT-1:0]          good_frame,
    input  logic [CNT-1:0]          drop_frame,
    output logic [CNT-1:0]          port_enable,
    output logic [CNT-1:0]          sfp_led
);

    import eth_loop_pkg::*;

    localparam int LW = $clog2(LED_HOLD + 1);

    // Register map
    localparam apb_addr_t ADDR_ENABLE = 8'h00;
    localparam apb_addr_t ADDR_STATUS = 8'h04;
    localparam apb_addr_t ADDR_COUNT  = 8'h10;

    count_t        good_cnt [CNT];
    count_t        drop_cnt [CNT];
    logic [LW-1:0] led_cnt  [CNT];

    logic          access;
    logic          hit;
    logic          read_only;

    // Address decode and read mux
    always_comb begin
        access    = psel && penable;
        hit       = 1'b0;
        read_only = 1'b1;
        prdata    = '0;
        if (paddr == ADDR_ENABLE) begin
            hit       = 1'b1;
            read_only = 1'b0;
            prdata    = apb_data_t'(port_enable);
        end else if (paddr == ADDR_STATUS) begin
            hit    = 1'b1;
            prdata = apb_data_t'(sfp_led);
        end
        // Counter pairs at 0x10 + 8n
        for (int n = 0; n < CNT; n++) begin
            if (paddr == ADDR_COUNT + apb_addr_t'(8 * n)) begin
                hit    = 1'b1;
                prdata = apb_data_t'(good_cnt[n]);
            end
            if (paddr == ADDR_COUNT + apb_addr_t'(8 * n + 4)) begin
                hit    = 1'b1;
                prdata = apb_data_t'(drop_cnt[n]);
            end
        end
        pready  = access;
        pslverr = access && (!hit || (pwrite && read_only));
    end

    // Enable register, the only writable one
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            port_enable <= '0;
        end else if (access && pwrite && paddr == ADDR_ENABLE) begin
            port_enable <= pwdata[CNT-1:0];
        end
    end

    for (genvar n = 0; n < CNT; n++) begin : g_port

        always_ff @(posedge clk_125mhz) begin
            if (reset) begin
                good_cnt[n] <= '0;
                drop_cnt[n] <= '0;
            end else begin
                if (good_frame[n]) begin
                    good_cnt[n] <= good_cnt[n] + 1'b1;
                end
                if (drop_frame[n]) begin
                    drop_cnt[n] <= drop_cnt[n] + 1'b1;
                end
            end
        end

        // LED hold timer restarts on every good frame
        always_ff @(posedge clk_125mhz) begin
            if (reset) begin
                led_cnt[n] <= '0;
            end else if (good_frame[n]) begin
                led_cnt[n] <= LW'(LED_HOLD);
            end else if (led_cnt[n] != '0) begin
                led_cnt[n] <= led_cnt[n] - 1'b1;
            end
        end

        assign sfp_led[n] = (led_cnt[n] != '0);

    end

endmodule

// ==== fpga_core.sv ====
// Two-port Ethernet loopback top level with frame FIFOs and an APB register block
`timescale 1ns/1ps

module fpga_core #(
    parameter int CNT       = 2,
    parameter int DEPTH     = 64,
    parameter int MAX_WORDS = 16,
    parameter int LED_HOLD  = 1024
) (
    input  logic                            clk_125mhz,
    input  logic                            reset,

    // APB slave
    input  eth_loop_pkg::apb_addr_t         paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  eth_loop_pkg::apb_data_t         pwdata,
    output eth_loop_pkg::apb_data_t         prdata,
    output logic                            pready,
    output logic                            pslverr,

    // Receive streams, one lane per port
    input  logic [CNT-1:0]                  rx_valid,
    input  eth_loop_pkg::word_t [CNT-1:0]   rx_data,
    input  eth_loop_pkg::keep_t [CNT-1:0]   rx_keep,
    input  logic [CNT-1:0]                  rx_last,
    input  logic [CNT-1:0]                  rx_user,

    // Transmit streams
    output logic [CNT-1:0]                  tx_valid,
    output eth_loop_pkg::word_t [CNT-1:0]   tx_data,
    output eth_loop_pkg::keep_t [CNT-1:0]   tx_keep,
    output logic [CNT-1:0]                  tx_last,
    input  logic [CNT-1:0]                  tx_ready,

    output logic [CNT-1:0]                  sfp_led
);

    logic [CNT-1:0] port_enable;
    logic [CNT-1:0] good_frame;
    logic [CNT-1:0] drop_frame;

    // One store-and-forward FIFO per port
    for (genvar n = 0; n < CNT; n++) begin : g_port
        frame_fifo #(
            .DEPTH     (DEPTH),
            .MAX_WORDS (MAX_WORDS)
        ) i_frame_fifo (
            .clk_125mhz  (clk_125mhz),
            .reset       (reset),
            .port_enable (port_enable[n]),
            .rx_valid    (rx_valid[n]),
            .rx_data     (rx_data[n]),
            .rx_keep     (rx_keep[n]),
            .rx_last     (rx_last[n]),
            .rx_user     (rx_user[n]),
            .tx_valid    (tx_valid[n]),
            .tx_data     (tx_data[n]),
            .tx_keep     (tx_keep[n]),
            .tx_last     (tx_last[n]),
            .tx_ready    (tx_ready[n]),
            .good_frame  (good_frame[n]),
            .drop_frame  (drop_frame[n])
        );
    end

    loop_regs #(
        .CNT      (CNT),
        .LED_HOLD (LED_HOLD)
    ) i_loop_regs (
        .clk_125mhz  (clk_125mhz),
        .reset       (reset),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .good_frame  (good_frame),
        .drop_frame  (drop_frame),
        .port_enable (port_enable),
        .sfp_led     (sfp_led)
    );

endmodule

// ==== fpga_core_assert.sv ====
// Protocol assertions on the transmit streams and APB port of the loopback top level
`timescale 1ns/1ps

module fpga_core_assert #(
    parameter int CNT = 2
) (
    input logic                          clk_125mhz,
    input logic                          reset,
    input logic                          psel,
    input logic                          penable,
    input logic                          pready,
    input logic                          pslverr,
    input logic [CNT-1:0]                tx_valid,
    input logic [CNT-1:0]                tx_ready,
    input eth_loop_pkg::word_t [CNT-1:0] tx_data,
    input eth_loop_pkg::keep_t [CNT-1:0] tx_keep,
    input logic [CNT-1:0]                tx_last
);

    // Stalled word must hold until taken
    for (genvar n = 0; n < CNT; n++) begin : g_port
        assert property (@(posedge clk_125mhz) disable iff (reset)
            tx_valid[n] && !tx_ready[n] |=> tx_valid[n] && $stable(tx_data[n])
                && $stable(tx_keep[n]) && $stable(tx_last[n]))
        else $error("tx stream %0d changed while stalled", n);
    end

    // Zero wait states
    assert property (@(posedge clk_125mhz) disable iff (reset)
        psel && penable |-> pready)
    else $error("pready low in APB access phase");

    assert property (@(posedge clk_125mhz) disable iff (reset)
        !(psel && penable) |-> !pslverr)
    else $error("pslverr high outside APB access phase");

endmodule

bind fpga_core fpga_core_assert #(.CNT(CNT)) i_fpga_core_assert (.*);

// ==== tb_fpga_core.sv ====
// Testbench for the loopback core, driven from a stimulus file with a model of frame fate
`timescale 1ns/1ps

module tb_fpga_core;

    import eth_loop_pkg::*;

    localparam int CNT       = 2;
    localparam int DEPTH     = 64;
    localparam int MAX_WORDS = 16;
    localparam int TIMEOUT   = 2000;

    logic                clk_125mhz = 1'b0;
    logic                reset;
    apb_addr_t           paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    apb_data_t           pwdata;
    apb_data_t           prdata;
    logic                pready;
    logic                pslverr;
    logic [CNT-1:0]      rx_valid;
    word_t [CNT-1:0]     rx_data;
    keep_t [CNT-1:0]     rx_keep;
    logic [CNT-1:0]      rx_last;
    logic [CNT-1:0]      rx_user;
    logic [CNT-1:0]      tx_valid;
    word_t [CNT-1:0]     tx_data;
    keep_t [CNT-1:0]     tx_keep;
    logic [CNT-1:0]      tx_last;
    logic [CNT-1:0]      tx_ready;
    logic [CNT-1:0]      sfp_led;

    // Expected words as {last, keep, data}
    logic [72:0]         exp_q0[$];
    logic [72:0]         exp_q1[$];
    logic [CNT-1:0]      en_model;
    logic [CNT-1:0]      hold;
    int                  committed [CNT];
    int                  out_words [CNT];
    int                  err_data;
    int                  err_reg;
    int                  err_other;
    logic                stop;

    fpga_core #(
        .CNT       (CNT),
        .DEPTH     (DEPTH),
        .MAX_WORDS (MAX_WORDS),
        .LED_HOLD  (32)
    ) i_fpga_core (.*);

    always #2 clk_125mhz = ~clk_125mhz;

    task automatic step();
        @(posedge clk_125mhz);
        #0.5;
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            err_data++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_keep(string name, keep_t got, keep_t exp);
        if (got !== exp) begin
            err_data++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_last(string name, logic got, logic exp);
        if (got !== exp) begin
            err_data++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            err_reg++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(string name, apb_data_t got, apb_data_t exp);
        if (got !== exp) begin
            err_reg++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic apb_access(logic write, apb_addr_t addr, apb_data_t data, logic exp_err);
        int waited;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        step();
        penable = 1'b1;
        waited  = 0;
        #1;
        while (!pready && waited < TIMEOUT) begin
            step();
            #1;
            waited++;
        end
        if (!pready) begin
            $display("Timeout: APB access to address %h never completed", addr);
            err_other++;
            stop = 1'b1;
        end else begin
            check_bit("pslverr", pslverr, exp_err);
            if (!write) begin
                check_reg("prdata", prdata, data);
                if (addr == 8'h04) begin
                    check_reg("sfp_led", apb_data_t'(sfp_led), data);
                end
            end
        end
        // Enable register is the only writable one
        if (write && addr == 8'h00) begin
            en_model = data[CNT-1:0];
        end
        step();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_frame(int p, int n, int err, word_t first, keep_t last_keep);
        int   level;
        logic pass;
        logic is_last;
        keep_t k;
        // Words in the RAM that the read side has not loaded yet
        level = committed[p] - out_words[p] - int'(tx_valid[p]);
        pass  = en_model[p] && (err == 0) && (n <= MAX_WORDS) && (DEPTH - level >= n);
        for (int i = 0; i < n; i++) begin
            is_last     = (i == n - 1);
            k           = is_last ? last_keep : 8'hff;
            rx_valid[p] = 1'b1;
            rx_data[p]  = first + word_t'(i);
            rx_keep[p]  = k;
            rx_last[p]  = is_last;
            rx_user[p]  = is_last && (err != 0);
            if (pass && p == 0) begin
                exp_q0.push_back({is_last, k, first + word_t'(i)});
            end else if (pass) begin
                exp_q1.push_back({is_last, k, first + word_t'(i)});
            end
            step();
        end
        rx_valid[p] = 1'b0;
        rx_last[p]  = 1'b0;
        rx_user[p]  = 1'b0;
        if (pass) begin
            committed[p] += n;
        end
        step();
        step();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && waited < TIMEOUT) begin
            step();
            waited++;
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            $display("Timeout: transmit streams did not deliver all expected words");
            err_other++;
            stop = 1'b1;
        end
        // Let status pulses reach the counters
        repeat (4) step();
    endtask

    // Random back-pressure unless a port is held
    always @(posedge clk_125mhz) begin
        #0.5;
        for (int p = 0; p < CNT; p++) begin
            tx_ready[p] = hold[p] ? 1'b0 : (($urandom % 4) != 0);
        end
    end

    // Transmit monitor
    always @(posedge clk_125mhz) begin : monitor
        logic [72:0] e;
        if (!reset) begin
            for (int p = 0; p < CNT; p++) begin
                if (tx_valid[p] && tx_ready[p]) begin
                    out_words[p]++;
                    if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0)) begin
                        $display("Unexpected word %h on transmit port %0d", tx_data[p], p);
                        err_other++;
                    end else begin
                        e = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
                        check_word("tx_data", tx_data[p], e[63:0]);
                        check_keep("tx_keep", tx_keep[p], e[71:64]);
                        check_last("tx_last", tx_last[p], e[72]);
                    end
                end
            end
        end
    end

    initial begin
        int        fd;
        int        code;
        int        port;
        int        words;
        int        err;
        string     cmd;
        string     line;
        apb_addr_t addr;
        apb_data_t data;
        word_t     first;
        keep_t     last_keep;
        void'($urandom(57));
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rx_valid  = '0;
        rx_data   = '0;
        rx_keep   = '0;
        rx_last   = '0;
        rx_user   = '0;
        tx_ready  = '0;
        hold      = '0;
        en_model  = '0;
        stop      = 1'b0;
        err_data  = 0;
        err_reg   = 0;
        err_other = 0;
        for (int p = 0; p < CNT; p++) begin
            committed[p] = 0;
            out_words[p] = 0;
        end
        repeat (10) @(posedge clk_125mhz);
        #0.5;
        reset = 1'b0;
        step();
        fd = $fopen("loop_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            err_other++;
            stop = 1'b1;
        end
        while (!stop && !$feof(fd)) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                break;
            end
            if (cmd.getc(0) == "#") begin
                code = $fgets(line, fd);
            end else if (cmd == "W" || cmd == "R") begin
                code = $fscanf(fd, "%h %h %d", addr, data, err);
                apb_access(cmd == "W", addr, data, err != 0);
            end else if (cmd == "F") begin
                code = $fscanf(fd, "%d %d %d %h %h", port, words, err, first, last_keep);
                send_frame(port, words, err, first, last_keep);
            end else if (cmd == "H") begin
                code = $fscanf(fd, "%d %d", port, err);
                hold[port] = (err != 0);
            end else if (cmd == "D") begin
                code = $fscanf(fd, "%d", words);
                repeat (words) step();
            end else if (cmd == "E") begin
                drain();
            end else begin
                $display("Unknown stimulus command %s", cmd);
                err_other++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (!stop) begin
            drain();
        end
        $display("Errors: data %0d, register %0d, other %0d", err_data, err_reg, err_other);
        if (err_data + err_reg + err_other == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== loop_stimulus.txt ====
# W addr data err | R addr expected_data expected_err | F port words err first_data last_keep
# H port hold | D idle_cycles | E wait until transmit streams drain
R 00 0 0
R 04 0 0
R 10 0 0
R 14 0 0
R 18 0 0
R 1c 0 0
F 0 4 0 1000 0f
F 1 3 0 2000 ff
E
R 10 0 0
R 14 0 0
R 18 0 0
W 00 3 0
R 00 3 0
# good frames on both ports
F 0 1 0 a000000000000100 01
F 1 8 0 b000000000000200 3f
F 0 16 0 a000000000000300 ff
F 1 2 0 b000000000000400 07
F 0 5 0 a000000000000500 1f
F 1 16 0 b000000000000600 01
E
R 10 3 0
R 18 3 0
# errored and oversize frames between good ones
F 0 3 1 c000000000000100 ff
F 0 17 0 c000000000000200 ff
F 0 2 0 c000000000000300 03
F 1 17 0 d000000000000100 ff
F 1 4 1 d000000000000200 0f
F 1 6 0 d000000000000300 7f
E
R 10 4 0
R 14 2 0
R 18 4 0
R 1c 2 0
# port 0 held until the RAM overflows
H 0 1
F 0 16 0 e000000000000100 ff
F 0 16 0 e000000000000200 ff
F 0 16 0 e000000000000300 ff
F 0 16 0 e000000000000400 ff
F 0 16 0 e000000000000500 ff
F 0 1 0 e000000000000600 01
F 0 1 0 e000000000000700 01
D 10
R 14 4 0
H 0 0
E
R 10 9 0
# LED follows the latest good frame
F 1 1 0 f000000000000100 01
E
R 04 2 0
D 40
R 04 0 0
# bad accesses
W 04 ff 1
W 10 ff 1
W 20 1 1
R 20 0 1
R 00 3 0
R 10 9 0
R 18 5 0

// ==== filelist.f ====
eth_loop_pkg.sv
frame_fifo.sv
loop_regs.sv
fpga_core.sv
fpga_core_assert.sv
tb_fpga_core.sv

// ==== Bender.yml ====
package:
  name: eth_loop

sources:
  - eth_loop_pkg.sv
  - frame_fifo.sv
  - loop_regs.sv
  - fpga_core.sv
  - target: test
    files:
      - fpga_core_assert.sv
      - tb_fpga_core.sv
